// ==== verilog/tgen_pkg.sv ====
package tgen_pkg;

	// Local bus data width, host side and downstream side alike
	localparam int lb_dw = 32;

	// One program word: delay, target address or data half-word
	localparam int half_w = 16;

	// Table index width per bank
	// 256 entries of four words each
	localparam int pc_w = 10;

	// Collision counter width
	localparam int count_w = 16;

	// Write data on the local buses
	typedef logic [lb_dw-1:0] lb_data_t;

	// Single program word as stored in the table RAM
	typedef logic [half_w-1:0] half_t;

	// Program counter, two low bits give the subcycle
	typedef logic [pc_w-1:0] pc_t;

	// Saturating collision count
	typedef logic [count_w-1:0] count_t;

	// Program table window
	// Compared against lb_addr above bit pc_w
	localparam logic [31:0] table_base = 32'h0000_0010;

	// Full local-bus address of the control register
	// Sits outside the table window
	localparam logic [31:0] ctrl_addr = 32'h0000_0100;

	// Control register layout
	// Bank to use at the next trigger
	localparam int ctrl_bank_bit = 0;
	// Write one to zero the collision count
	localparam int ctrl_clear_bit = 1;
	// Upper address bits of every generated write start here
	localparam int ctrl_pad_lsb = 2;

endpackage

// ==== verilog/dpram.sv ====
`timescale 1ns/1ns

module dpram #(
	parameter int dw = tgen_pkg::half_w,
	parameter int aw = tgen_pkg::pc_w + 1
) (
	input logic clk,
	// Write port
	input logic [aw-1:0] addra,
	input logic [dw-1:0] dina,
	input logic wena,
	// Read port
	input logic [aw-1:0] addrb,
	output logic [dw-1:0] doutb
);

	// Number of words
	localparam int depth = 1 << aw;

	// Storage array
	// Maps onto one block RAM for the default sizes
	logic [dw-1:0] mem [0:depth-1];

	// Write side
	// One word per cycle while wena is high
	always_ff @(posedge clk) begin
		if (wena) begin
			mem[addra] <= dina;
		end
	end

	// Read side
	// Data for addrb shows up one cycle later
	// A same-address write in that cycle gives the old word
	always_ff @(posedge clk) begin
		doutb <= mem[addrb];
	end

endmodule

// ==== verilog/lb_ctrl.sv ====
`timescale 1ns/1ns

module lb_ctrl #(
	parameter int aw = 17
) (
	input logic clk,
	input logic rst_n,
	// Host write bus
	input logic [aw-1:0] lb_addr,
	input tgen_pkg::lb_data_t lb_data,
	input logic lb_write,
	// Strobe from the sequencer merge stage
	input logic collision,
	// Table write enable, same cycle as lb_write
	output logic dests_write,
	// Control register fields
	output logic bank_next,
	output logic [aw-17:0] addr_padding,
	// Lost generated writes so far
	output tgen_pkg::count_t collision_count
);

	import tgen_pkg::*;

	// Width of the padding field
	localparam int pad_w = aw - 16;

	// Number of address bits above the table index
	localparam int win_w = aw - pc_w;

	// Upper address bits of the current host cycle
	logic [win_w-1:0] win_sel;

	// Host cycle hits the control register
	logic ctrl_write;

	// Control write with the clear bit set
	logic clear_req;

	// Counter has reached all ones
	logic count_full;

	// Table window decode
	// Purely combinational, so the RAM write lands in the same cycle
	assign win_sel = lb_addr[aw-1:pc_w];
	assign dests_write = lb_write && (win_sel == table_base[win_w-1:0]);

	// Control register decode
	// Full address match
	assign ctrl_write = lb_write && (lb_addr == ctrl_addr[aw-1:0]);

	// Clear request travels with the control write itself
	// Bit is a strobe, it is not stored
	assign clear_req = ctrl_write && lb_data[ctrl_clear_bit];

	// Saturation detect
	assign count_full = &collision_count;

	// Control register
	// Every write reloads all fields at once
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bank_next <= 1'b0;
			addr_padding <= '0;
		end else if (ctrl_write) begin
			// Bank request, picked up by the sequencer at its next trigger
			bank_next <= lb_data[ctrl_bank_bit];
			// Upper bits for generated write addresses
			addr_padding <= lb_data[ctrl_pad_lsb +: pad_w];
		end
	end

	// Collision counter
	// Clear wins over a collision in the same cycle
	// Holds at all ones once saturated
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			collision_count <= '0;
		end else if (clear_req) begin
			collision_count <= '0;
		end else if (collision && !count_full) begin
			collision_count <= collision_count + 1'b1;
		end
	end

endmodule

// ==== verilog/tgen.sv ====
`timescale 1ns/1ns

module tgen #(
	parameter int aw = 17,
	parameter int tgen_gran = 0
) (
	input logic clk,
	input logic rst_n,
	// Start request, sampled every cycle
	input logic trig,
	// Host write bus
	input tgen_pkg::lb_data_t lb_data,
	input logic [aw-1:0] lb_addr,
	input logic lb_write,
	// From the decode stage
	input logic dests_write,
	input logic bank_next,
	input logic [aw-17:0] addr_padding,
	// Downstream write bus
	output tgen_pkg::lb_data_t lbo_data,
	output logic [aw-1:0] lbo_addr,
	output logic lbo_write,
	// Generated write lost to a host write
	output logic collision,
	// Previous work flag, previous bank, current bank, requested bank
	output logic [3:0] status
);

	import tgen_pkg::*;

	// Delay timer width, extended by the tick granularity
	localparam int timer_w = 16 + tgen_gran;

	// Sequencer state
	pc_t pc;
	logic [1:0] subcycle;
	logic [timer_w-1:0] timer;
	logic trig_start;
	logic trig_d;
	logic step;
	logic zero_addr;
	logic did_work;

	// Bank state, updated only when a program starts
	logic bank;
	logic bank_prev;
	logic work_prev;

	// Table RAM and read pipeline
	logic [pc_w:0] host_addr;
	logic [pc_w:0] seq_addr;
	half_t mem_out;
	half_t mem_out1;
	half_t mem_out2;
	logic mem_zero;
	logic write_cycle;

	// Assembled generated write
	lb_data_t gen_data;
	logic [aw-1:0] gen_addr;

	// Host write that goes straight through
	logic write_thru;

	// Low pc bits select the word within an entry
	// 0 delay, 1 target, 2 low data, 3 high data
	assign subcycle = pc[1:0];

	// Start only from idle, and only once per rising trigger at pc 0
	assign trig_start = trig && (pc == '0) && !trig_d;

	// End of program
	// Target word was zero, seen at subcycle 3 through mem_zero
	assign zero_addr = (subcycle == 2'd3) && mem_zero;

	// Idle waits for the delayed start
	// Subcycle 0 stalls until the timer runs out, others always advance
	assign step = (pc == '0) ? trig_d : ((subcycle != 2'd0) || (timer == '0));

	// Program counter, delay timer and work flag
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
			timer <= '0;
			trig_d <= 1'b0;
			did_work <= 1'b0;
		end else begin
			trig_d <= trig_start;
			if (zero_addr) begin
				pc <= '0;
			end else if (step) begin
				pc <= pc + 1'b1;
			end
			// Delay word is on the RAM output during subcycle 1
			if (subcycle == 2'd1) begin
				timer <= timer_w'(mem_out) << tgen_gran;
			end else if ((subcycle == 2'd0) && (timer != '0)) begin
				timer <= timer - 1'b1;
			end
			// Set once the first entry has finished
			if (trig_start) begin
				did_work <= 1'b0;
			end else if (pc[2]) begin
				did_work <= 1'b1;
			end
		end
	end

	// Bank flip at program start
	// Host keeps writing the bank the sequencer does not read
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bank <= 1'b0;
			bank_prev <= 1'b0;
			work_prev <= 1'b0;
		end else if (trig_start) begin
			bank <= bank_next;
			bank_prev <= bank;
			work_prev <= did_work;
		end
	end

	// Host side addresses the bank selected by bank, sequencer the other one
	assign host_addr = {bank, lb_addr[pc_w-1:0]};
	assign seq_addr = {~bank, pc};

	dpram #(
		.dw(half_w),
		.aw(pc_w + 1)
	) i_dests (
		.clk(clk),
		.addra(host_addr),
		.dina(lb_data[half_w-1:0]),
		.wena(dests_write),
		.addrb(seq_addr),
		.doutb(mem_out)
	);

	// Read results trail the pc by one and two words
	always_ff @(posedge clk) begin
		mem_out1 <= mem_out;
		mem_out2 <= mem_out1;
	end

	// Zero target detect and generated write strobe
	// write_cycle lines up with high data on mem_out
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_zero <= 1'b0;
			write_cycle <= 1'b0;
		end else begin
			mem_zero <= (mem_out == '0);
			write_cycle <= (subcycle == 2'd3) && !mem_zero;
		end
	end

	// High word still on the RAM, low word and target one and two stages back
	assign gen_data = {mem_out, mem_out1};
	assign gen_addr = {addr_padding, mem_out2};

	// Table writes stay out of the downstream bus
	assign write_thru = lb_write && !dests_write;

	// Output payload, host write has priority
	always_ff @(posedge clk) begin
		lbo_data <= write_thru ? lb_data : gen_data;
		lbo_addr <= write_thru ? lb_addr : gen_addr;
	end

	// Output strobes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lbo_write <= 1'b0;
			collision <= 1'b0;
		end else begin
			lbo_write <= write_thru || write_cycle;
			collision <= write_thru && write_cycle;
		end
	end

	assign status = {work_prev, bank_prev, bank, bank_next};

endmodule

// ==== verilog/tgen_top.sv ====
`timescale 1ns/1ns

module tgen_top #(
	parameter int aw = 17,
	parameter int tgen_gran = 0
) (
	input logic clk,
	input logic rst_n,
	// External start request
	input logic trig,
	// Host write bus
	input tgen_pkg::lb_data_t lb_data,
	input logic [aw-1:0] lb_addr,
	input logic lb_write,
	// Downstream write bus
	output tgen_pkg::lb_data_t lbo_data,
	output logic [aw-1:0] lbo_addr,
	output logic lbo_write,
	// Monitoring
	output logic collision,
	output tgen_pkg::count_t collision_count,
	output logic [3:0] status
);

	// Decode stage to sequencer
	logic dests_write;
	logic bank_next;
	logic [aw-17:0] addr_padding;

	// Address decode, control register and collision count
	lb_ctrl #(
		.aw(aw)
	) i_lb_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.lb_addr(lb_addr),
		.lb_data(lb_data),
		.lb_write(lb_write),
		.collision(collision),
		.dests_write(dests_write),
		.bank_next(bank_next),
		.addr_padding(addr_padding),
		.collision_count(collision_count)
	);

	// Program sequencer and bus merge
	tgen #(
		.aw(aw),
		.tgen_gran(tgen_gran)
	) i_tgen (
		.clk(clk),
		.rst_n(rst_n),
		.trig(trig),
		.lb_data(lb_data),
		.lb_addr(lb_addr),
		.lb_write(lb_write),
		.dests_write(dests_write),
		.bank_next(bank_next),
		.addr_padding(addr_padding),
		.lbo_data(lbo_data),
		.lbo_addr(lbo_addr),
		.lbo_write(lbo_write),
		.collision(collision),
		.status(status)
	);

endmodule

// ==== bench/tgen_tb.sv ====
`timescale 1ns/1ns

module tgen_tb;

	import tgen_pkg::*;

	localparam int aw = 17;

	logic clk;
	logic rst_n;
	logic trig;
	lb_data_t lb_data;
	logic [aw-1:0] lb_addr;
	logic lb_write;
	lb_data_t lbo_data;
	logic [aw-1:0] lbo_addr;
	logic lbo_write;
	logic collision;
	count_t collision_count;
	logic [3:0] status;

	// Model state: two bank images, bank bits, work flags and padding
	half_t image [0:1][0:(1<<pc_w)-1];
	logic bank_m;
	logic bank_prev_m;
	logic bank_next_m;
	logic work_m;
	logic work_prev_m;
	logic [aw-17:0] pad_m;

	// Expected generated writes and the gap to the next one
	logic [aw-1:0] q_addr [$];
	lb_data_t q_data [$];
	int q_gap [$];

	// Monitor state
	logic prev_valid;
	logic [aw-1:0] prev_addr;
	lb_data_t prev_data;
	logic gen_armed;
	int next_due;
	int now;
	int lost_total;
	int errors;
	int seed;
	int budget;
	int wd_cyc;

	tgen_top #(
		.aw(aw),
		.tgen_gran(1)
	) i_tgen_top (
		.clk(clk),
		.rst_n(rst_n),
		.trig(trig),
		.lb_data(lb_data),
		.lb_addr(lb_addr),
		.lb_write(lb_write),
		.lbo_data(lbo_data),
		.lbo_addr(lbo_addr),
		.lbo_write(lbo_write),
		.collision(collision),
		.collision_count(collision_count),
		.status(status)
	);

	always #5 clk = ~clk;

	function automatic logic in_table(input logic [aw-1:0] a);
		return a[aw-1:pc_w] == table_base[aw-pc_w-1:0];
	endfunction

	// Output monitor, sampled mid-cycle where everything is settled
	always @(negedge clk) begin
		if (rst_n) begin
			now++;
			if (prev_valid) begin
				assert (lbo_write && lbo_addr == prev_addr && lbo_data == prev_data)
				else begin
					$display("** Error pass-through: expected %h/%h, got %b %h/%h",
						prev_addr, prev_data, lbo_write, lbo_addr, lbo_data);
					errors++;
				end
				if (gen_armed && now == next_due) begin
					// Generated write due here is lost to the host write
					assert (collision)
					else begin
						$display("** Error collision: expected 1, got %b", collision);
						errors++;
					end
					lost_total++;
					next_due = now + q_gap[0];
					void'(q_addr.pop_front());
					void'(q_data.pop_front());
					void'(q_gap.pop_front());
					gen_armed = (q_addr.size() > 0);
				end else begin
					assert (!collision)
					else begin
						$display("** Error collision: expected 0, got %b", collision);
						errors++;
					end
				end
			end else if (lbo_write) begin
				if (q_addr.size() == 0) begin
					$display("Generated write %h/%h appeared with none expected",
						lbo_addr, lbo_data);
					errors++;
				end else begin
					assert (lbo_addr == q_addr[0] && lbo_data == q_data[0])
					else begin
						$display("** Error playback: expected %h/%h, got %h/%h",
							q_addr[0], q_data[0], lbo_addr, lbo_data);
						errors++;
					end
					if (gen_armed) begin
						assert (now == next_due)
						else begin
							$display("** Error spacing: expected cycle %0d, got %0d",
								next_due, now);
							errors++;
						end
					end
					next_due = now + q_gap[0];
					void'(q_addr.pop_front());
					void'(q_data.pop_front());
					void'(q_gap.pop_front());
					gen_armed = (q_addr.size() > 0);
				end
			end
			// Host cycle now on the inputs shows up at the next sample
			prev_valid = lb_write && !in_table(lb_addr);
			prev_addr = lb_addr;
			prev_data = lb_data;
		end
	end

	// Watchdog, limit grows with every program loaded
	always @(posedge clk) begin
		wd_cyc++;
		if (wd_cyc > 4 * budget + 5000) begin
			$display("Watchdog expired, the run did not complete in time");
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic host_write(input logic [aw-1:0] a, input lb_data_t d);
		lb_addr = a;
		lb_data = d;
		lb_write = 1'b1;
		if (in_table(a)) begin
			image[bank_m][a[pc_w-1:0]] = d[15:0];
		end
		tick();
		lb_write = 1'b0;
	endtask

	task automatic set_ctrl(input logic bnk, input logic clr, input logic [aw-17:0] pad);
		lb_data_t d;
		d = '0;
		d[ctrl_bank_bit] = bnk;
		d[ctrl_clear_bit] = clr;
		d[ctrl_pad_lsb +: aw-16] = pad;
		bank_next_m = bnk;
		pad_m = pad;
		host_write(ctrl_addr[aw-1:0], d);
	endtask

	task automatic random_passthru();
		logic [aw-1:0] a;
		a = aw'($random(seed));
		if (in_table(a) || a == ctrl_addr[aw-1:0]) begin
			a[aw-1] = ~a[aw-1];
		end
		host_write(a, $random(seed));
	endtask

	// Random program of 3 to 8 entries plus the zero entry
	task automatic load_program();
		int n;
		int base;
		n = 3 + ($unsigned($random(seed)) % 6);
		base = table_base[aw-pc_w-1:0] << pc_w;
		for (int i = 0; i <= n; i++) begin
			half_t dly;
			half_t tgt;
			dly = (i == n) ? 16'd0 : half_t'($unsigned($random(seed)) % 16);
			tgt = (i == n) ? 16'd0 : (half_t'($random(seed)) | 16'h0001);
			host_write(aw'(base + 4 * i), lb_data_t'(dly));
			host_write(aw'(base + 4 * i + 1), lb_data_t'(tgt));
			host_write(aw'(base + 4 * i + 2), $random(seed));
			host_write(aw'(base + 4 * i + 3), $random(seed));
			budget += 8 + 2 * dly;
		end
	endtask

	task automatic trigger();
		logic sb;
		sb = ~bank_next_m;
		for (int i = 0; i < 256; i++) begin
			if (image[sb][4*i+1] == '0) break;
			q_addr.push_back({pad_m, image[sb][4*i+1]});
			q_data.push_back({image[sb][4*i+3], image[sb][4*i+2]});
			q_gap.push_back(4 + (int'(image[sb][4*i]) << 1));
		end
		// Work flag of the run that ended, then of the run about to start
		work_prev_m = work_m;
		work_m = (q_addr.size() > 0);
		trig = 1'b1;
		tick();
		trig = 1'b0;
		bank_prev_m = bank_m;
		bank_m = bank_next_m;
		tick();
		assert (status == {work_prev_m, bank_prev_m, bank_m, bank_next_m})
		else begin
			$display("** Error status: expected %b, got %b",
				{work_prev_m, bank_prev_m, bank_m, bank_next_m}, status);
			errors++;
		end
	endtask

	task automatic wait_first();
		int n;
		n = 0;
		while (!gen_armed && q_addr.size() > 0 && n < 300) begin
			tick();
			n++;
		end
		if (n >= 300) begin
			$display("First generated write did not appear");
			errors++;
		end
	endtask

	task automatic finish_run(input logic inject);
		int n;
		logic forced;
		n = 0;
		forced = 1'b0;
		while (q_addr.size() > 0 && n < 2000) begin
			if (inject && !forced && gen_armed && next_due == now + 2) begin
				// Host write lands on the output cycle of the next generated write
				forced = 1'b1;
				random_passthru();
			end else if (inject && ($unsigned($random(seed)) % 4 == 0)) begin
				random_passthru();
			end else begin
				tick();
			end
			n++;
		end
		if (n >= 2000) begin
			$display("Program playback did not finish");
			errors++;
		end
		// Quiet tail, nothing more may appear
		repeat (60) tick();
	endtask

	task automatic check_count(input string name);
		assert (collision_count == count_t'(lost_total))
		else begin
			$display("** Error %s: expected %0d, got %0d", name, lost_total, collision_count);
			errors++;
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		trig = 1'b0;
		lb_data = '0;
		lb_addr = '0;
		lb_write = 1'b0;
		seed = 220;
		budget = 400;
		{now, lost_total, errors, wd_cyc, next_due} = '0;
		{bank_m, bank_prev_m, bank_next_m, pad_m, gen_armed, prev_valid} = '0;
		{work_m, work_prev_m} = '0;
		for (int b = 0; b < 2; b++) begin
			for (int i = 0; i < (1 << pc_w); i++) begin
				image[b][i] = '0;
			end
		end
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		tick();

		// Pass-through, table writes and control writes mixed
		for (int i = 0; i < 60; i++) begin
			case ($unsigned($random(seed)) % 4)
				0: host_write(aw'((table_base[aw-pc_w-1:0] << pc_w) + 900 + i), $random(seed));
				1: set_ctrl(1'b0, 1'b0, pad_m + 1'b1);
				default: random_passthru();
			endcase
		end
		repeat (4) tick();

		// Plain playback with a fresh padding value
		load_program();
		set_ctrl(~bank_m, 1'b0, 1'b1);
		trigger();
		wait_first();
		finish_run(1'b0);

		// Bank switch while a program plays, with host traffic injected
		load_program();
		set_ctrl(~bank_m, 1'b0, pad_m);
		trigger();
		wait_first();
		load_program();
		set_ctrl(~bank_m, 1'b0, pad_m);
		finish_run(1'b1);
		trigger();
		wait_first();
		finish_run(1'b1);
		check_count("collision count");

		// Clear, then count again from zero
		set_ctrl(bank_next_m, 1'b1, pad_m);
		tick();
		lost_total = 0;
		check_count("count clear");
		load_program();
		set_ctrl(~bank_m, 1'b0, 1'b0);
		trigger();
		wait_first();
		finish_run(1'b1);
		check_count("count resume");

		$display("Checks done, errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== list.f ====
verilog/tgen_pkg.sv
verilog/dpram.sv
verilog/lb_ctrl.sv
verilog/tgen.sv
verilog/tgen_top.sv
bench/tgen_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module tgen_tb -o tgen_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tgen_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
	exit 0
else
	exit 1
fi
